// ==== Bender.yml ====
package:
  name: pwm_subsystem

sources:
  - source/pwm_pkg.sv
  - source/pwm_timer.sv
  - source/pwm_channel.sv
  - source/reg_bus_port.sv
  - source/pwm_subsystem.sv
  - target: test
    files:
      - tests/pwm_subsystem_checker.sv
      - tests/pwm_subsystem_tb.sv

// ==== compile.f ====
source/pwm_pkg.sv
source/pwm_timer.sv
source/pwm_channel.sv
source/reg_bus_port.sv
source/pwm_subsystem.sv
tests/pwm_subsystem_checker.sv
tests/pwm_subsystem_tb.sv

// ==== source/pwm_channel.sv ====
// pwm channel
// period, on-time and config registers of one channel, the status
// word built from enable and the live output, and the period timer
module pwm_channel import pwm_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          wr_en,
   input  chan_write_t   wr,
   output pwm_readback_t readback,
   output logic          pwm_out
);

   logic [COUNT_WIDTH-1:0] period_q;
   logic [COUNT_WIDTH-1:0] on_time_q;
   logic                   enable_q;
   logic                   enable_next;

   // config bit 0 as it will be after this edge
   assign enable_next = (wr_en && (wr.reg_sel == PWM_CONFIG)) ? wr.wdata[0] : enable_q;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_q  <= '0;
         on_time_q <= '0;
         enable_q  <= 1'b0;
      end else begin
         enable_q <= enable_next;
         if (wr_en) begin
            case (wr.reg_sel)
               PWM_PERIOD:  period_q  <= wr.wdata[COUNT_WIDTH-1:0];
               PWM_ON_TIME: on_time_q <= wr.wdata[COUNT_WIDTH-1:0];
               default:     ;
            endcase
         end
      end
   end

   // timer follows the config register in the same cycle,
   // so the output drops at the edge that clears enable
   pwm_timer u_timer (
      .clk          (clk),
      .reset        (reset),
      .enable       (enable_next),
      .period       (period_q),
      .on_time      (on_time_q),
      .pwm          (pwm_out),
      .period_start ()
   );

   assign readback.period      = period_q;
   assign readback.on_time     = on_time_q;
   assign readback.config_word = DATA_WIDTH'(enable_q);
   // status: bit 1 live level, bit 0 enable
   assign readback.status_word = DATA_WIDTH'({pwm_out, enable_q});

endmodule

// ==== source/pwm_pkg.sv ====
// pwm subsystem package
// bus widths, the per-channel register map and the packed types
// shared by the register bus port, the channels and the top level
package pwm_pkg;

   localparam int DATA_WIDTH     = 32;
   localparam int COUNT_WIDTH    = 16;
   localparam int REG_SEL_WIDTH  = 2;
   localparam int CHAN_SEL_WIDTH = 4;

   // register offsets inside one channel
   typedef enum logic [REG_SEL_WIDTH-1:0] {
      PWM_PERIOD  = 2'd0,
      PWM_ON_TIME = 2'd1,
      PWM_CONFIG  = 2'd2,
      PWM_STATUS  = 2'd3
   } pwm_reg_e;

   // host request, one per credit
   typedef struct packed {
      logic                      write;
      logic [CHAN_SEL_WIDTH-1:0] chan;
      pwm_reg_e                  reg_sel;
      logic [DATA_WIDTH-1:0]     wdata;
   } bus_req_t;

   // read response, writes get none
   typedef struct packed {
      logic [DATA_WIDTH-1:0] rdata;
   } bus_rsp_t;

   // decoded write, shared by all channels
   // counts use the low COUNT_WIDTH bits, config uses bit 0
   typedef struct packed {
      pwm_reg_e              reg_sel;
      logic [DATA_WIDTH-1:0] wdata;
   } chan_write_t;

   // everything a channel can return on a read
   typedef struct packed {
      logic [COUNT_WIDTH-1:0] period;
      logic [COUNT_WIDTH-1:0] on_time;
      logic [DATA_WIDTH-1:0]  config_word;
      logic [DATA_WIDTH-1:0]  status_word;
   } pwm_readback_t;

endpackage

// ==== source/pwm_subsystem.sv ====
// pwm subsystem top level
// register bus port in front of NUM_CHANNELS independent pwm channels
module pwm_subsystem import pwm_pkg::*; #(
   parameter int NUM_CHANNELS = 4,
   parameter int REQ_DEPTH    = 4
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req_valid,
   input  bus_req_t                req,
   output logic                    req_credit,
   output logic                    rsp_valid,
   output bus_rsp_t                rsp,
   output logic [NUM_CHANNELS-1:0] pwm_out
);

   logic [NUM_CHANNELS-1:0] wr_en;
   chan_write_t             wr;
   pwm_readback_t           readback [NUM_CHANNELS];

   reg_bus_port #(
      .NUM_CHANNELS (NUM_CHANNELS),
      .REQ_DEPTH    (REQ_DEPTH)
   ) u_bus_port (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .wr_en      (wr_en),
      .wr         (wr),
      .readback   (readback)
   );

   // one channel per strobe, all share the decoded write
   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gen_chan
      pwm_channel u_channel (
         .clk      (clk),
         .reset    (reset),
         .wr_en    (wr_en[i]),
         .wr       (wr),
         .readback (readback[i]),
         .pwm_out  (pwm_out[i])
      );
   end

endmodule

// ==== source/pwm_timer.sv ====
// pwm period timer
// down-counts the period and on-time of each window and drives the
// registered pwm level, new values are taken only at a reload
module pwm_timer import pwm_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   input  logic [COUNT_WIDTH-1:0] period,
   input  logic [COUNT_WIDTH-1:0] on_time,
   output logic                   pwm,
   output logic                   period_start
);

   typedef enum logic [1:0] {
      IDLE,
      HIGH,
      LOW
   } state_e;

   state_e                 state;
   logic [COUNT_WIDTH-1:0] period_cnt;
   logic [COUNT_WIDTH-1:0] on_cnt;
   logic                   period_done;
   logic                   reload;

   // last cycle of the running window
   assign period_done = (state != IDLE) && (period_cnt == '0);
   // start from idle or roll into the next window
   assign reload      = enable && (period != '0) && ((state == IDLE) || period_done);

   // control FSM
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state        <= IDLE;
         pwm          <= 1'b0;
         period_start <= 1'b0;
      end else begin
         period_start <= reload;
         if (!enable) begin
            state <= IDLE;
            pwm   <= 1'b0;
         end else if (reload) begin
            state <= (on_time != '0) ? HIGH : LOW;
            pwm   <= (on_time != '0);
         end else if (period_done) begin
            // period was set to zero while running
            state <= IDLE;
            pwm   <= 1'b0;
         end else if ((state == HIGH) && (on_cnt == '0)) begin
            state <= LOW;
            pwm   <= 1'b0;
         end
      end
   end

   // counters hold the cycles left after the current one
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_cnt <= '0;
         on_cnt     <= '0;
      end else if (reload) begin
         period_cnt <= period - 1'b1;
         on_cnt     <= on_time - 1'b1;
      end else if (state != IDLE) begin
         if (period_cnt != '0) begin
            period_cnt <= period_cnt - 1'b1;
         end
         if ((state == HIGH) && (on_cnt != '0)) begin
            on_cnt <= on_cnt - 1'b1;
         end
      end
   end

endmodule

// ==== source/reg_bus_port.sv ====
// register bus port
// queues credit-controlled host requests, pops one per cycle, decodes
// channel and register, drives the channel write strobes and returns
// read data on a registered response stream
module reg_bus_port import pwm_pkg::*; #(
   parameter int NUM_CHANNELS = 4,
   parameter int REQ_DEPTH    = 4
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req_valid,
   input  bus_req_t                req,
   output logic                    req_credit,
   output logic                    rsp_valid,
   output bus_rsp_t                rsp,
   output logic [NUM_CHANNELS-1:0] wr_en,
   output chan_write_t             wr,
   input  pwm_readback_t           readback [NUM_CHANNELS]
);

   localparam int PTR_WIDTH  = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int COUNT_BITS = $clog2(REQ_DEPTH + 1);

   bus_req_t              queue [REQ_DEPTH];
   logic [PTR_WIDTH-1:0]  wr_ptr;
   logic [PTR_WIDTH-1:0]  rd_ptr;
   logic [COUNT_BITS-1:0] count;
   bus_req_t              head;
   logic                  pop;
   logic                  read_pop;
   pwm_readback_t         sel;
   logic [DATA_WIDTH-1:0] rdata;

   function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
      if (ptr == PTR_WIDTH'(REQ_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // head entry leaves whenever anything is queued
   assign head     = queue[rd_ptr];
   assign pop      = (count != '0);
   assign read_pop = pop && !head.write;

   // request storage
   always_ff @(posedge clk) begin
      if (req_valid) begin
         queue[wr_ptr] <= req;
      end
   end

   // pointers and occupancy, credits keep the host from overfilling
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (req_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({req_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // channel select, an absent channel leaves sel cleared and reads zero
   always_comb begin
      sel = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         if (head.chan == CHAN_SEL_WIDTH'(i)) begin
            sel = readback[i];
         end
      end
   end

   // one-hot strobe, status is read only
   always_comb begin
      wr_en = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         wr_en[i] = pop && head.write && (head.reg_sel != PWM_STATUS) &&
                    (head.chan == CHAN_SEL_WIDTH'(i));
      end
   end

   assign wr = '{reg_sel: head.reg_sel, wdata: head.wdata};

   always_comb begin
      case (head.reg_sel)
         PWM_PERIOD:  rdata = DATA_WIDTH'(sel.period);
         PWM_ON_TIME: rdata = DATA_WIDTH'(sel.on_time);
         PWM_CONFIG:  rdata = sel.config_word;
         default:     rdata = sel.status_word;
      endcase
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         rsp_valid  <= 1'b0;
         req_credit <= 1'b0;
      end else begin
         rsp_valid  <= read_pop;
         req_credit <= pop;
      end
   end

   // response data only moves on a read
   always_ff @(posedge clk) begin
      if (read_pop) begin
         rsp <= '{rdata: rdata};
      end
   end

endmodule

// ==== tests/pwm_subsystem_checker.sv ====
// pwm subsystem assertion checker
// bound to the top level, watches reset values, enable gating of the
// outputs, request queue occupancy and response timing
module pwm_subsystem_checker import pwm_pkg::*; #(
   parameter int NUM_CHANNELS = 4,
   parameter int REQ_DEPTH    = 4
) (
   input logic                           clk,
   input logic                           reset,
   input logic                           req_valid,
   input bus_req_t                       req,
   input logic                           req_credit,
   input logic                           rsp_valid,
   input logic [NUM_CHANNELS-1:0]        pwm_out,
   input pwm_readback_t                  readback [NUM_CHANNELS],
   input logic [$clog2(REQ_DEPTH+1)-1:0] count
);

   int reads_open;

   // host reads taken in and not answered yet
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         reads_open <= 0;
      end else begin
         reads_open <= reads_open + int'(req_valid && !req.write) - int'(rsp_valid);
      end
   end

   reset_outputs_low: assert property (@(posedge clk)
      !reset |-> (!req_credit && !rsp_valid && (pwm_out == '0)))
      else $error("outputs not low while reset is active");

   occupancy_in_range: assert property (@(posedge clk) disable iff (!reset)
      count <= REQ_DEPTH)
      else $error("request queue holds more than REQ_DEPTH entries");

   // a response only answers a read the host sent
   rsp_answers_read: assert property (@(posedge clk) disable iff (!reset)
      rsp_valid |-> (reads_open > 0))
      else $error("rsp_valid without an open read request");

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gen_gate
      pwm_low_when_disabled: assert property (@(posedge clk) disable iff (!reset)
         !readback[i].config_word[0] |-> !pwm_out[i])
         else $error("pwm output high on a disabled channel");
   end

endmodule

bind pwm_subsystem pwm_subsystem_checker #(
   .NUM_CHANNELS (NUM_CHANNELS),
   .REQ_DEPTH    (REQ_DEPTH)
) u_checker (
   .clk        (clk),
   .reset      (reset),
   .req_valid  (req_valid),
   .req        (req),
   .req_credit (req_credit),
   .rsp_valid  (rsp_valid),
   .pwm_out    (pwm_out),
   .readback   (readback),
   .count      (u_bus_port.count)
);

// ==== tests/pwm_subsystem_tb.sv ====
// pwm subsystem testbench
// table driven register writes, readback, duty cycle counting,
// a credit-limited read burst and an ignored status write
module pwm_subsystem_tb import pwm_pkg::*; ();

   localparam int NUM_CHANNELS = 4;
   localparam int REQ_DEPTH    = 4;
   localparam int NUM_ROWS     = 6;

   typedef struct packed {
      logic [CHAN_SEL_WIDTH-1:0] chan;
      logic [COUNT_WIDTH-1:0]    period;
      logic [COUNT_WIDTH-1:0]    on_time;
      logic                      enable;
      logic [COUNT_WIDTH-1:0]    high;
   } row_t;

   // high count is 4 x min(on_time, period), zero when disabled
   localparam row_t ROWS [NUM_ROWS] = '{
      '{4'd0, 16'd10, 16'd3, 1'b1, 16'd12},
      '{4'd1, 16'd8,  16'd8, 1'b1, 16'd32},
      '{4'd2, 16'd6,  16'd9, 1'b1, 16'd24},
      '{4'd3, 16'd12, 16'd0, 1'b1, 16'd0},
      '{4'd1, 16'd7,  16'd4, 1'b0, 16'd0},
      '{4'd0, 16'd10, 16'd3, 1'b1, 16'd12}
   };

   logic                    clk;
   logic                    reset;
   logic                    req_valid;
   bus_req_t                req;
   logic                    req_credit;
   logic                    rsp_valid;
   bus_rsp_t                rsp;
   logic [NUM_CHANNELS-1:0] pwm_out;
   int                      credits;
   int                      cycles;
   int                      limit;
   int                      seed = 20302;
   bus_rsp_t                rsp_q [$];
   logic [COUNT_WIDTH-1:0]  model_period [NUM_CHANNELS];
   logic [COUNT_WIDTH-1:0]  model_on [NUM_CHANNELS];
   logic                    model_en [NUM_CHANNELS];

   pwm_subsystem #(
      .NUM_CHANNELS (NUM_CHANNELS),
      .REQ_DEPTH    (REQ_DEPTH)
   ) DUT (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .pwm_out    (pwm_out)
   );

   always #10 clk = ~clk;

   task automatic fail_run();
      $display("Checks failed");
      $fatal(1, "testbench stopped at the first failure");
   endtask

   task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h",
                  $time, name, exp.rdata, act.rdata);
         fail_run();
      end
   endtask

   task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] exp,
                              input logic [COUNT_WIDTH-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
         fail_run();
      end
   endtask

   // disabled or zero duty channels sit low and full duty ones sit high
   // partial duty ones move inside their period and are not checked here
   task automatic check_steady(input int c);
      if (!model_en[c] || (model_period[c] == '0) || (model_on[c] == '0)) begin
         check_level($sformatf("pwm_out[%0d]", c), 1'b0, pwm_out[c]);
      end else if (model_on[c] >= model_period[c]) begin
         check_level($sformatf("pwm_out[%0d]", c), 1'b1, pwm_out[c]);
      end
   endtask

   // spends one credit, waits for a returned one when none is left
   task automatic send(input bus_req_t r);
      while (credits == 0) begin
         @(posedge clk);
         #2;
      end
      credits--;
      req_valid = 1'b1;
      req       = r;
      @(posedge clk);
      #2;
      req_valid = 1'b0;
   endtask

   task automatic write_reg(input logic [CHAN_SEL_WIDTH-1:0] chan, input pwm_reg_e r,
                            input logic [DATA_WIDTH-1:0] data);
      send('{write: 1'b1, chan: chan, reg_sel: r, wdata: data});
   endtask

   task automatic issue_read(input logic [CHAN_SEL_WIDTH-1:0] chan, input pwm_reg_e r);
      send('{write: 1'b0, chan: chan, reg_sel: r, wdata: '0});
   endtask

   task automatic read_reg(input logic [CHAN_SEL_WIDTH-1:0] chan, input pwm_reg_e r,
                           output bus_rsp_t data);
      issue_read(chan, r);
      while (rsp_q.size() == 0) begin
         @(posedge clk);
         #2;
      end
      data = rsp_q.pop_front();
   endtask

   // host side of the response stream and the credit return
   always @(posedge clk) begin
      if (rsp_valid) begin
         rsp_q.push_back(rsp);
      end
      if (req_credit) begin
         credits++;
         if (credits > REQ_DEPTH) begin
            $display("more credits came back than requests were sent");
            fail_run();
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout, the run hung after %0d cycles", cycles);
         fail_run();
      end
   end

   initial begin
      bus_rsp_t got;
      bus_rsp_t expect_q [$];
      row_t     row;
      int       high;
      int       chan;
      clk       = 1'b0;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      credits   = REQ_DEPTH;
      cycles    = 0;
      // each row settles two periods and counts four, plus bus traffic
      limit     = 200;
      foreach (ROWS[i]) limit += 8 * ROWS[i].period + 60;
      foreach (model_period[i]) begin
         model_period[i] = '0;
         model_on[i]     = '0;
         model_en[i]     = 1'b0;
      end
      #2 reset = 1'b0;
      repeat (5) @(posedge clk);
      check_level("req_credit", 1'b0, req_credit);
      check_level("rsp_valid", 1'b0, rsp_valid);
      check_level("pwm_out", 1'b0, |pwm_out);
      #2 reset = 1'b1;

      for (int i = 0; i < NUM_ROWS; i++) begin
         row = ROWS[i];
         // random upper bits must be masked off by the channel
         write_reg(row.chan, PWM_PERIOD, {16'($random(seed)), row.period});
         write_reg(row.chan, PWM_ON_TIME, {16'($random(seed)), row.on_time});
         write_reg(row.chan, PWM_CONFIG, {31'($random(seed)), row.enable});
         model_period[row.chan] = row.period;
         model_on[row.chan]     = row.on_time;
         model_en[row.chan]     = row.enable;
         read_reg(row.chan, PWM_PERIOD, got);
         check_rsp("period", bus_rsp_t'(32'(row.period)), got);
         read_reg(row.chan, PWM_ON_TIME, got);
         check_rsp("on_time", bus_rsp_t'(32'(row.on_time)), got);
         read_reg(row.chan, PWM_CONFIG, got);
         check_rsp("config", bus_rsp_t'(32'(row.enable)), got);
         read_reg(row.chan, PWM_STATUS, got);
         check_level("status enable", row.enable, got.rdata[0]);
         repeat (2 * row.period) @(posedge clk);
         high = 0;
         repeat (4 * row.period) begin
            @(posedge clk);
            #2;
            if (pwm_out[row.chan]) high++;
            if (!row.enable) check_level("pwm_out", 1'b0, pwm_out[row.chan]);
            // the other channels keep running on their own settings
            for (int c = 0; c < NUM_CHANNELS; c++) begin
               if (c != row.chan) begin
                  check_steady(c);
               end
            end
         end
         check_count("high cycles", row.high, 16'(high));
      end

      read_reg(4'd5, PWM_PERIOD, got);
      check_rsp("absent channel", '0, got);

      // status is read only, bit 0 cleared so a stray config write shows
      write_reg(4'd0, PWM_STATUS, {31'($random(seed)), 1'b0});
      read_reg(4'd0, PWM_PERIOD, got);
      check_rsp("period after status write", bus_rsp_t'(32'(model_period[0])), got);
      read_reg(4'd0, PWM_CONFIG, got);
      check_rsp("config after status write", bus_rsp_t'(32'(model_en[0])), got);

      // back-to-back reads, two of them to absent channels
      for (int i = 0; i < 10; i++) begin
         chan = i % 6;
         expect_q.push_back((chan < NUM_CHANNELS) ? bus_rsp_t'(32'(model_period[chan])) : '0);
         issue_read(4'(chan), PWM_PERIOD);
      end
      while (rsp_q.size() < 10) begin
         @(posedge clk);
         #2;
      end
      foreach (expect_q[i]) check_rsp("burst rdata", expect_q[i], rsp_q.pop_front());
      while (credits != REQ_DEPTH) begin
         @(posedge clk);
         #2;
      end
      repeat (4) @(posedge clk);
      check_count("extra responses", '0, 16'(rsp_q.size()));

      $display("All checks passed");
      $finish;
   end

endmodule
